// ==== isa_pkg.sv ====
/*
 * isa encodings for the decode stage
 * opcode and funct codes, field positions, decoder control encodings
 */
package isa_pkg;

    // field positions --------------------
    localparam int op_lsb = 26;
    localparam int rs_lsb = 21;
    localparam int rt_lsb = 16;
    localparam int rd_lsb = 11;
    localparam int sa_lsb = 6;

    // opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct codes under op_special
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    // decoder controls, one-hot --------------------
    typedef enum logic [11:0] {
        alu_none = 12'h000,
        alu_add  = 12'h001,
        alu_sub  = 12'h002,
        alu_and  = 12'h004,
        alu_or   = 12'h008,
        alu_xor  = 12'h010,
        alu_slt  = 12'h020,
        alu_sll  = 12'h040,
        alu_lui  = 12'h080   // bits 8 to 11 spare
    } alu_op_e;

    typedef enum logic [2:0] {ext_none = 3'b000, ext_sign = 3'b001, ext_zero = 3'b010,
                              ext_sl2 = 3'b100} ext_mode_e;
    typedef enum logic [2:0] {bj_none = 3'b000, bj_branch = 3'b001,
                              bj_jump = 3'b010} bjpc_e;
    typedef enum logic [6:0] {br_none = 7'h00, br_eq = 7'h01, br_ne = 7'h02} brcal_e;
    typedef enum logic [4:0] {wb_none = 5'h00, wb_alu = 5'h01, wb_mem = 5'h02,
                              wb_link = 5'h04} sel_wb_e;
    typedef enum logic [1:0] {dm_none = 2'b00, dm_read = 2'b01, dm_write = 2'b10} sel_dm_e;
    typedef enum logic [2:0] {dst_none = 3'b000, dst_rt = 3'b001, dst_rd = 3'b010,
                              dst_r31 = 3'b100} wr_dst_e;

endpackage

// ==== pipe_pkg.sv ====
/*
 * pipeline-wide types and constants
 * register numbers, write and read types, reset pc values
 */
package pipe_pkg;

    typedef logic [4:0]  reg_num_t;
    typedef logic [31:0] word_t;

    localparam int       num_regs = 32;
    localparam reg_num_t ra_reg   = 5'd31;   // link register for jal

    // write type --------------------
    // one-hot on the stage whose result is first ready
    // bit 0 wb, bit 1 mem, bit 2 exe, zero for no write
    typedef logic [2:0] write_type_t;
    localparam write_type_t wt_none = 3'b000;
    localparam write_type_t wt_mem  = 3'b010;
    localparam write_type_t wt_exe  = 3'b100;

    // read type, which source fields are really read
    typedef logic [1:0] read_type_t;
    localparam read_type_t rd_none = 2'b00;
    localparam read_type_t rd_rs   = 2'b01;
    localparam read_type_t rd_rt   = 2'b10;
    localparam read_type_t rd_both = 2'b11;

    // loaded on reset and whenever the stage drains
    localparam word_t reset_pc   = 32'hbfc0_0000;
    localparam word_t reset_nnpc = 32'hbfc0_0008;

endpackage

// ==== src_if.sv ====
`timescale 1ns/10ps
/*
 * source operand bundle between the stage controller and the hazard checker
 */
interface src_if import pipe_pkg::*; ();

    reg_num_t   rs;
    reg_num_t   rt;
    read_type_t read_type;
    logic       ready;       // no pending write on a used source

    modport ctl (output rs, output rt, output read_type, input ready);
    modport chk (input rs, input rt, input read_type, output ready);

endinterface

// ==== reg_file.sv ====
`timescale 1ns/10ps
/*
 * 32 x 32-bit register file
 * byte-enabled write port, two combinational read ports, r0 fixed at zero
 */
module reg_file import pipe_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] wen,      // byte lanes
    input  reg_num_t   wnum,
    input  word_t      wdata,
    input  reg_num_t   rnum1,
    input  reg_num_t   rnum2,
    output word_t      rdata1,
    output word_t      rdata2
);

    word_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wnum != '0) begin   // r0 is never written
            for (int b = 0; b < 4; b++) begin
                if (wen[b]) begin
                    regs[wnum][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // old value shows in the writing cycle
    assign rdata1 = regs[rnum1];
    assign rdata2 = regs[rnum2];

endmodule

// ==== instr_decoder.sv ====
`timescale 1ns/10ps
/*
 * instruction decoder
 * field split and control generation for the integer subset
 */
module instr_decoder import isa_pkg::*, pipe_pkg::*; (
    input  word_t       instr,
    output reg_num_t    rs,
    output reg_num_t    rt,
    output reg_num_t    rd,
    output reg_num_t    sa,
    output logic [15:0] imm,
    output logic [25:0] instr_index,
    output wr_dst_e     wr_dst,
    output logic        sel_alud1,    // high picks sa
    output logic        sel_alud2,    // high picks the extended immediate
    output ext_mode_e   ext_mode,
    output bjpc_e       bjpc,
    output brcal_e      brcal,
    output alu_op_e     alu_op,
    output sel_dm_e     sel_dm,
    output sel_wb_e     sel_wb,
    output read_type_t  read_type,
    output write_type_t write_type,
    output logic        nop
);

    logic [5:0] op;
    logic [5:0] funct;

    // field split --------------------
    assign op          = instr[op_lsb +: 6];
    assign rs          = instr[rs_lsb +: 5];
    assign rt          = instr[rt_lsb +: 5];
    assign rd          = instr[rd_lsb +: 5];
    assign sa          = instr[sa_lsb +: 5];
    assign funct       = instr[5:0];
    assign imm         = instr[15:0];
    assign instr_index = instr[25:0];

    // control generation --------------------
    always_comb begin
        wr_dst     = dst_none;
        sel_alud1  = 1'b0;
        sel_alud2  = 1'b0;
        ext_mode   = ext_none;
        bjpc       = bj_none;
        brcal      = br_none;
        alu_op     = alu_none;
        sel_dm     = dm_none;
        sel_wb     = wb_none;
        read_type  = rd_none;
        write_type = wt_none;
        nop        = 1'b0;
        case (op)
            op_special: begin
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sll: begin
                        if (instr != '0) begin   // all-zero word stays a nop
                            alu_op = alu_sll;
                        end
                    end
                    default: alu_op = alu_none;
                endcase
                if (alu_op == alu_none) begin
                    nop = 1'b1;
                end else begin
                    wr_dst     = dst_rd;
                    sel_wb     = wb_alu;
                    write_type = wt_exe;
                    read_type  = rd_both;
                    if (alu_op == alu_sll) begin
                        sel_alud1 = 1'b1;
                        read_type = rd_rt;   // rs field unused by shifts
                    end
                end
            end
            op_addiu, op_andi, op_ori, op_lui: begin
                wr_dst     = dst_rt;
                sel_alud2  = 1'b1;
                sel_wb     = wb_alu;
                write_type = wt_exe;
                read_type  = (op == op_lui) ? rd_none : rd_rs;
                ext_mode   = ext_zero;
                case (op)
                    op_addiu: begin
                        alu_op   = alu_add;
                        ext_mode = ext_sign;
                    end
                    op_andi: alu_op = alu_and;
                    op_ori:  alu_op = alu_or;
                    default: alu_op = alu_lui;
                endcase
            end
            op_lw, op_sw: begin
                alu_op    = alu_add;   // base plus offset
                ext_mode  = ext_sign;
                sel_alud2 = 1'b1;
                if (op == op_lw) begin
                    wr_dst     = dst_rt;
                    sel_dm     = dm_read;
                    sel_wb     = wb_mem;
                    write_type = wt_mem;
                    read_type  = rd_rs;
                end else begin
                    sel_dm    = dm_write;
                    read_type = rd_both;
                end
            end
            op_beq, op_bne: begin
                ext_mode  = ext_sl2;
                bjpc      = bj_branch;
                read_type = rd_both;
                brcal     = (op == op_beq) ? br_eq : br_ne;
            end
            op_j, op_jal: begin
                bjpc = bj_jump;
                if (op == op_jal) begin
                    wr_dst     = dst_r31;
                    sel_wb     = wb_link;
                    write_type = wt_exe;
                end
            end
            default: nop = 1'b1;   // unknown opcode
        endcase
    end

endmodule

// ==== hazard_check.sv ====
`timescale 1ns/10ps
/*
 * read-after-write hazard check
 * holds decode while exe, mem or wb still owes a used source register
 */
module hazard_check import pipe_pkg::*; (
    input  write_type_t exe_write_type,
    input  write_type_t mem_write_type,
    input  write_type_t wb_write_type,
    input  reg_num_t    exe_wnum,
    input  reg_num_t    mem_wnum,
    input  reg_num_t    wb_wnum,
    src_if.chk          src
);

    logic exe_hit;
    logic mem_hit;
    logic wb_hit;

    // one later stage against both sources
    function automatic logic clash(write_type_t wt, reg_num_t wnum, reg_num_t rs,
                                   reg_num_t rt, read_type_t used);
        logic live;
        logic rs_hit;
        logic rt_hit;
        live   = (wt != wt_none) && (wnum != '0);   // r0 never carries a result
        rs_hit = ((used & rd_rs) != rd_none) && (wnum == rs);
        rt_hit = ((used & rd_rt) != rd_none) && (wnum == rt);
        return live && (rs_hit || rt_hit);
    endfunction

    assign exe_hit = clash(exe_write_type, exe_wnum, src.rs, src.rt, src.read_type);
    assign mem_hit = clash(mem_write_type, mem_wnum, src.rs, src.rt, src.read_type);
    assign wb_hit  = clash(wb_write_type, wb_wnum, src.rs, src.rt, src.read_type);

    assign src.ready = !(exe_hit || mem_hit || wb_hit);   // no forwarding, always stall

endmodule

// ==== id_stage.sv ====
`timescale 1ns/10ps
/*
 * decode stage controller
 * valid/allowin handshake, pc and instruction latch, operands and masking
 */
module id_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // handshake and fetch data
    input  logic        if_valid,
    input  word_t       if_pc,
    input  word_t       if_nnpc,
    input  word_t       if_instr,
    input  logic        exe_allowin,
    output logic        id_allowin,
    output logic        id_valid,
    // decoder side
    output word_t       instr,
    input  reg_num_t    rs,
    input  reg_num_t    rt,
    input  reg_num_t    rd,
    input  reg_num_t    sa,
    input  logic [15:0] imm,
    input  wr_dst_e     wr_dst,
    input  logic        sel_alud1,
    input  logic        sel_alud2,
    input  ext_mode_e   ext_mode,
    input  sel_dm_e     dec_sel_dm,
    input  sel_wb_e     dec_sel_wb,
    input  read_type_t  read_type,
    input  write_type_t dec_write_type,
    input  logic        nop,
    input  word_t       rdata1,
    input  word_t       rdata2,
    src_if.ctl          src,
    // results
    output word_t       aludata1,
    output word_t       aludata2,
    output word_t       rd1,
    output word_t       rd2,
    output word_t       extend_res,
    output reg_num_t    regnum,
    output word_t       id_pc,
    output word_t       id_nnpc,
    output logic [1:0]  sel_dm,
    output logic [4:0]  sel_wb,
    output write_type_t write_type
);

    logic     valid;
    logic     live;   // a real instruction sits in the stage
    reg_num_t dst;

    // handshake --------------------
    assign id_allowin = !valid || (src.ready && exe_allowin);
    assign id_valid   = valid && src.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (id_allowin) begin
            valid <= if_valid;
        end
    end

    // pc and instruction latch, back to reset values when nothing arrives
    always_ff @(posedge clk) begin
        if (!rst_n || (id_allowin && !if_valid)) begin
            id_pc   <= reset_pc;
            id_nnpc <= reset_nnpc;
            instr   <= '0;   // decodes as nop
        end else if (id_allowin) begin
            id_pc   <= if_pc;
            id_nnpc <= if_nnpc;
            instr   <= if_instr;
        end
    end

    assign src.rs        = rs;
    assign src.rt        = rt;
    assign src.read_type = read_type;

    // immediate extension --------------------
    always_comb begin
        case (ext_mode)
            ext_zero: extend_res = {16'b0, imm};
            ext_sl2:  extend_res = {{14{imm[15]}}, imm, 2'b00};   // branch offset
            default:  extend_res = {{16{imm[15]}}, imm};
        endcase
    end

    // operands
    assign aludata1 = sel_alud1 ? {27'b0, sa} : rdata1;
    assign aludata2 = sel_alud2 ? extend_res : rdata2;
    assign rd1      = rdata1;
    assign rd2      = rdata2;

    // destination and masking --------------------
    always_comb begin
        case (wr_dst)
            dst_rt:  dst = rt;
            dst_rd:  dst = rd;
            default: dst = ra_reg;
        endcase
    end

    assign live       = valid && !nop;
    assign regnum     = dst & {5{live}};
    assign write_type = dec_write_type & {3{live}};
    assign sel_dm     = dec_sel_dm & {2{valid}};
    assign sel_wb     = dec_sel_wb & {5{valid}};

endmodule

// ==== decode_top.sv ====
`timescale 1ns/10ps
/*
 * instruction decode stage top
 * joins stage controller, decoder, register file and hazard checker
 */
module decode_top import isa_pkg::*, pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        if_valid,
    input  word_t       if_pc,
    input  word_t       if_nnpc,
    input  word_t       if_instr,
    input  logic        exe_allowin,
    output logic        id_allowin,
    output logic        id_valid,
    // later-stage destinations
    input  write_type_t exe_write_type,
    input  write_type_t mem_write_type,
    input  write_type_t wb_write_type,
    input  reg_num_t    exe_wnum,
    input  reg_num_t    mem_wnum,
    input  reg_num_t    wb_wnum,   // also the write-back register
    // write-back port
    input  logic [3:0]  wb_wen,
    input  word_t       wb_wdata,
    // decode results
    output word_t       aludata1,
    output word_t       aludata2,
    output word_t       rd1,
    output word_t       rd2,
    output word_t       extend_res,
    output alu_op_e     alu_op,
    output logic [1:0]  sel_dm,
    output logic [4:0]  sel_wb,
    output write_type_t write_type,
    output reg_num_t    regnum,
    output word_t       id_pc,
    output word_t       id_nnpc,
    output logic [25:0] instr_index,
    output bjpc_e       bjpc,
    output brcal_e      brcal
);

    word_t       instr;
    reg_num_t    rs;
    reg_num_t    rt;
    reg_num_t    rd;
    reg_num_t    sa;
    logic [15:0] imm;
    wr_dst_e     wr_dst;
    logic        sel_alud1;
    logic        sel_alud2;
    ext_mode_e   ext_mode;
    sel_dm_e     dec_sel_dm;
    sel_wb_e     dec_sel_wb;
    read_type_t  read_type;
    write_type_t dec_write_type;
    logic        nop;
    word_t       rdata1;
    word_t       rdata2;

    src_if src ();

    // decoder outputs not renamed here go straight to the top ports
    instr_decoder decoder_i (
        .sel_dm     (dec_sel_dm),
        .sel_wb     (dec_sel_wb),
        .write_type (dec_write_type),
        .*
    );

    id_stage id_stage_i (.*);

    reg_file reg_file_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (wb_wen),
        .wnum   (wb_wnum),
        .wdata  (wb_wdata),
        .rnum1  (rs),
        .rnum2  (rt),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    hazard_check hazard_check_i (
        .exe_write_type (exe_write_type),
        .mem_write_type (mem_write_type),
        .wb_write_type  (wb_write_type),
        .exe_wnum       (exe_wnum),
        .mem_wnum       (mem_wnum),
        .wb_wnum        (wb_wnum),
        .src            (src)
    );

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/10ps
/*
 * testbench clock and reset, 4 ns period, reset held 10 cycles
 */
module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;   // released off the edge like other inputs
    end

endmodule

// ==== tb_decode.sv ====
`timescale 1ns/10ps
/*
 * testbench for the decode stage
 * drives fetch and later-stage ports, checks outputs against a decode model
 */
module tb_decode import isa_pkg::*, pipe_pkg::*; ();

    localparam int timeout = 50;

    logic        clk;
    logic        rst_n;
    logic        if_valid;
    word_t       if_pc;
    word_t       if_nnpc;
    word_t       if_instr;
    logic        exe_allowin;
    logic        id_allowin;
    logic        id_valid;
    write_type_t exe_write_type;
    write_type_t mem_write_type;
    write_type_t wb_write_type;
    reg_num_t    exe_wnum;
    reg_num_t    mem_wnum;
    reg_num_t    wb_wnum;
    logic [3:0]  wb_wen;
    word_t       wb_wdata;
    word_t       aludata1;
    word_t       aludata2;
    word_t       rd1;
    word_t       rd2;
    word_t       extend_res;
    alu_op_e     alu_op;
    logic [1:0]  sel_dm;
    logic [4:0]  sel_wb;
    write_type_t write_type;
    reg_num_t    regnum;
    word_t       id_pc;
    word_t       id_nnpc;
    logic [25:0] instr_index;
    bjpc_e       bjpc;
    brcal_e      brcal;

    word_t model [32];   // expected register contents
    int    errors;
    int    test_errors;
    int    tests;
    int    failed_tests;
    word_t pc;

    tb_clkgen clkgen_i (.clk(clk), .rst_n(rst_n));

    decode_top decode_top_i (.*);

    // checking and reporting --------------------
    task automatic check_val(string name, word_t exp, word_t act);
        assert (act === exp) else begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic start_test();
        test_errors = errors;
    endtask

    task automatic end_test(string name);
        tests++;
        if (errors != test_errors) begin
            failed_tests++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic give_up(string what);
        $display("timeout waiting for %s", what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // handshake properties --------------------
    assert property (@(posedge clk) disable iff (!rst_n)
                     (id_valid && !exe_allowin) |-> !id_allowin)
    else begin
        $display("id_allowin stayed high while exe held the stage");
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
                     (id_valid && !exe_allowin) |=> ($stable(id_pc) && $stable(aludata1)
                     && $stable(aludata2) && $stable(regnum) && $stable(write_type)))
    else begin
        $display("decode outputs changed while exe held the stage");
        errors++;
    end

    // instruction encoding
    function automatic word_t enc_r(reg_num_t rs, reg_num_t rt, reg_num_t rd, reg_num_t sa,
                                    logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, reg_num_t rs, reg_num_t rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t sext(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // stimulus --------------------
    task automatic issue(word_t ins, word_t ipc);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        while (!id_allowin) begin
            if (n >= timeout) give_up("id_allowin");
            @(posedge clk);
            #1;
            n++;
        end
        if_valid = 1'b1;
        if_instr = ins;
        if_pc    = ipc;
        if_nnpc  = ipc + 32'd8;
        @(posedge clk);
        #1;
        if_valid = 1'b0;
        if_instr = '0;
        #1;   // sample mid-cycle
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!id_valid) begin
            if (n >= timeout) give_up("id_valid");
            @(posedge clk);
            #2;
            n++;
        end
    endtask

    task automatic write_reg(reg_num_t num, logic [3:0] wen, word_t data);
        @(posedge clk);
        #1;
        wb_wen   = wen;
        wb_wnum  = num;
        wb_wdata = data;
        for (int b = 0; b < 4; b++) begin
            if (wen[b] && num != 5'd0) model[num][8*b +: 8] = data[8*b +: 8];
        end
        @(posedge clk);
        #1;
        wb_wen = 4'h0;
    endtask

    // checks one decoded instruction and skips regnum when exp_rn is negative
    task automatic decode_case(string name, word_t ins, alu_op_e e_alu, write_type_t e_wt,
                               sel_wb_e e_wb, bjpc_e e_bj, brcal_e e_br, int exp_rn,
                               word_t e_a1, word_t e_a2);
        pc = pc + 32'd4;
        issue(ins, pc);
        wait_valid();
        check_val({name, " alu_op"}, 32'(e_alu), 32'(alu_op));
        check_val({name, " write_type"}, 32'(e_wt), 32'(write_type));
        check_val({name, " sel_wb"}, 32'(e_wb), 32'(sel_wb));
        check_val({name, " bjpc"}, 32'(e_bj), 32'(bjpc));
        check_val({name, " brcal"}, 32'(e_br), 32'(brcal));
        if (exp_rn >= 0) check_val({name, " regnum"}, 32'(exp_rn), 32'(regnum));
        check_val({name, " aludata1"}, e_a1, aludata1);
        check_val({name, " aludata2"}, e_a2, aludata2);
        check_val({name, " id_nnpc"}, pc + 32'd8, id_nnpc);
    endtask

    // main sequence --------------------
    initial begin
        reg_num_t    rs;
        reg_num_t    rt;
        reg_num_t    rd;
        reg_num_t    sa;
        logic [15:0] imm;
        logic [25:0] idx;
        word_t       snap [6];
        int          n;

        void'($urandom(32'h2796));
        if_valid       = 1'b0;
        if_pc          = '0;
        if_nnpc        = '0;
        if_instr       = '0;
        exe_allowin    = 1'b1;
        exe_write_type = '0;
        mem_write_type = '0;
        wb_write_type  = '0;
        exe_wnum       = '0;
        mem_wnum       = '0;
        wb_wnum        = '0;
        wb_wen         = '0;
        wb_wdata       = '0;
        errors         = 0;
        tests          = 0;
        failed_tests   = 0;
        pc             = 32'h0000_1000;
        for (int i = 0; i < 32; i++) model[i] = '0;

        // reset state
        start_test();
        @(posedge clk);
        #2;
        n = 0;
        while (!rst_n) begin
            if (n >= timeout) give_up("reset release");
            check_val("reset id_valid", 32'(1'b0), 32'(id_valid));
            check_val("reset id_allowin", 32'(1'b1), 32'(id_allowin));
            @(posedge clk);
            #2;
            n++;
        end
        check_val("reset id_valid", 32'(1'b0), 32'(id_valid));
        check_val("reset id_allowin", 32'(1'b1), 32'(id_allowin));
        check_val("reset regnum", 0, 32'(regnum));
        check_val("reset write_type", 0, 32'(write_type));
        check_val("reset sel_dm", 0, 32'(sel_dm));
        check_val("reset sel_wb", 0, 32'(sel_wb));
        end_test("reset");

        // register write and read-back
        start_test();
        write_reg(5'd0, 4'hf, 32'hdead_beef);
        for (int k = 0; k < 10; k++) write_reg(5'($urandom()), 4'hf, $urandom());
        write_reg(5'd7, 4'b0101, $urandom());   // partial lanes
        for (int k = 0; k < 8; k++) begin
            rs = (k == 0) ? 5'd0 : 5'($urandom());
            rt = (k == 1) ? 5'd0 : 5'($urandom());
            pc = pc + 32'd4;
            issue(enc_r(rs, rt, 5'd1, 5'd0, fn_addu), pc);
            wait_valid();
            check_val("regfile rd1", model[rs], rd1);
            check_val("regfile rd2", model[rt], rd2);
        end
        end_test("regfile");

        // decode and operands
        start_test();
        for (int k = 0; k < 3; k++) begin
            rs  = 5'($urandom());
            rt  = 5'($urandom());
            rd  = 5'($urandom()) | 5'd1;   // keeps sll from being the zero word
            sa  = 5'($urandom());
            imm = 16'($urandom());
            idx = 26'($urandom());
            decode_case("addu", enc_r(rs, rt, rd, sa, fn_addu), alu_add, wt_exe, wb_alu,
                        bj_none, br_none, int'(rd), model[rs], model[rt]);
            decode_case("subu", enc_r(rs, rt, rd, sa, fn_subu), alu_sub, wt_exe, wb_alu,
                        bj_none, br_none, int'(rd), model[rs], model[rt]);
            decode_case("and", enc_r(rs, rt, rd, sa, fn_and), alu_and, wt_exe, wb_alu,
                        bj_none, br_none, int'(rd), model[rs], model[rt]);
            decode_case("or", enc_r(rs, rt, rd, sa, fn_or), alu_or, wt_exe, wb_alu,
                        bj_none, br_none, int'(rd), model[rs], model[rt]);
            decode_case("xor", enc_r(rs, rt, rd, sa, fn_xor), alu_xor, wt_exe, wb_alu,
                        bj_none, br_none, int'(rd), model[rs], model[rt]);
            decode_case("slt", enc_r(rs, rt, rd, sa, fn_slt), alu_slt, wt_exe, wb_alu,
                        bj_none, br_none, int'(rd), model[rs], model[rt]);
            decode_case("sll", enc_r(5'd0, rt, rd, sa, fn_sll), alu_sll, wt_exe, wb_alu,
                        bj_none, br_none, int'(rd), {27'b0, sa}, model[rt]);
            decode_case("addiu", enc_i(op_addiu, rs, rt, imm), alu_add, wt_exe, wb_alu,
                        bj_none, br_none, int'(rt), model[rs], sext(imm));
            decode_case("andi", enc_i(op_andi, rs, rt, imm), alu_and, wt_exe, wb_alu,
                        bj_none, br_none, int'(rt), model[rs], {16'b0, imm});
            decode_case("ori", enc_i(op_ori, rs, rt, imm), alu_or, wt_exe, wb_alu,
                        bj_none, br_none, int'(rt), model[rs], {16'b0, imm});
            decode_case("lui", enc_i(op_lui, rs, rt, imm), alu_lui, wt_exe, wb_alu,
                        bj_none, br_none, int'(rt), model[rs], {16'b0, imm});
            decode_case("lw", enc_i(op_lw, rs, rt, imm), alu_add, wt_mem, wb_mem,
                        bj_none, br_none, int'(rt), model[rs], sext(imm));
            check_val("lw sel_dm", 32'(dm_read), 32'(sel_dm));
            decode_case("sw", enc_i(op_sw, rs, rt, imm), alu_add, wt_none, wb_none,
                        bj_none, br_none, -1, model[rs], sext(imm));
            check_val("sw sel_dm", 32'(dm_write), 32'(sel_dm));
            decode_case("beq", enc_i(op_beq, rs, rt, imm), alu_none, wt_none, wb_none,
                        bj_branch, br_eq, -1, model[rs], model[rt]);
            check_val("beq extend_res", sext(imm) << 2, extend_res);
            decode_case("bne", enc_i(op_bne, rs, rt, imm), alu_none, wt_none, wb_none,
                        bj_branch, br_ne, -1, model[rs], model[rt]);
            check_val("bne extend_res", sext(imm) << 2, extend_res);
            decode_case("j", {op_j, idx}, alu_none, wt_none, wb_none, bj_jump, br_none, -1,
                        model[idx[25:21]], model[idx[20:16]]);
            check_val("j instr_index", 32'(idx), 32'(instr_index));
            decode_case("jal", {op_jal, idx}, alu_none, wt_exe, wb_link, bj_jump, br_none,
                        31, model[idx[25:21]], model[idx[20:16]]);
            check_val("jal instr_index", 32'(idx), 32'(instr_index));
        end
        end_test("decode");

        // hazard stall on a used source
        start_test();
        @(posedge clk);
        #1;
        exe_wnum       = 5'd9;
        exe_write_type = wt_exe;
        pc = pc + 32'd4;
        issue(enc_r(5'd9, 5'd2, 5'd3, 5'd0, fn_addu), pc);
        for (int k = 0; k < 3; k++) begin
            check_val("stall id_valid", 32'(1'b0), 32'(id_valid));
            check_val("stall id_allowin", 32'(1'b0), 32'(id_allowin));
            check_val("stall id_pc", pc, id_pc);
            @(posedge clk);
            #2;
        end
        #3;
        exe_write_type = wt_none;
        #1;
        wait_valid();
        check_val("stall release id_pc", pc, id_pc);
        @(posedge clk);
        #1;
        exe_write_type = wt_exe;
        pc = pc + 32'd4;
        issue(enc_i(op_lui, 5'd9, 5'd4, 16'h1234), pc);   // rs field unused
        check_val("unused source id_valid", 32'(1'b1), 32'(id_valid));
        @(posedge clk);
        #1;
        exe_wnum = 5'd0;
        pc = pc + 32'd4;
        issue(enc_r(5'd0, 5'd0, 5'd5, 5'd0, fn_addu), pc);
        check_val("r0 source id_valid", 32'(1'b1), 32'(id_valid));
        @(posedge clk);
        #1;
        exe_write_type = wt_none;
        end_test("hazard");

        // back-pressure
        start_test();
        @(posedge clk);
        #1;
        exe_allowin = 1'b0;
        pc = pc + 32'd4;
        issue(enc_i(op_ori, 5'd3, 5'd6, 16'hbeef), pc);
        wait_valid();
        snap = '{aludata1, aludata2, 32'(regnum), id_pc, 32'(write_type), 32'(alu_op)};
        @(posedge clk);
        #1;
        if_valid = 1'b1;
        if_instr = enc_i(op_andi, 5'd4, 5'd8, 16'h00ff);
        if_pc    = pc + 32'd4;
        if_nnpc  = pc + 32'd12;
        for (int k = 0; k < 4; k++) begin
            #1;
            check_val("hold id_allowin", 32'(1'b0), 32'(id_allowin));
            check_val("hold id_valid", 32'(1'b1), 32'(id_valid));
            check_val("hold aludata1", snap[0], aludata1);
            check_val("hold aludata2", snap[1], aludata2);
            check_val("hold regnum", snap[2], 32'(regnum));
            check_val("hold id_pc", snap[3], id_pc);
            check_val("hold write_type", snap[4], 32'(write_type));
            check_val("hold alu_op", snap[5], 32'(alu_op));
            @(posedge clk);
            #1;
        end
        exe_allowin = 1'b1;
        @(posedge clk);
        #1;
        if_valid = 1'b0;
        #1;
        pc = pc + 32'd4;
        check_val("release id_pc", pc, id_pc);
        check_val("release id_valid", 32'(1'b1), 32'(id_valid));
        end_test("backpressure");

        // bubbles, nop and unknown opcode
        start_test();
        @(posedge clk);
        #2;
        check_val("empty id_valid", 32'(1'b0), 32'(id_valid));
        check_val("empty regnum", 0, 32'(regnum));
        check_val("empty write_type", 0, 32'(write_type));
        check_val("empty id_pc", reset_pc, id_pc);
        check_val("empty id_nnpc", reset_nnpc, id_nnpc);
        pc = pc + 32'd4;
        issue(32'h0000_0000, pc);
        wait_valid();
        check_val("nop regnum", 0, 32'(regnum));
        check_val("nop write_type", 0, 32'(write_type));
        pc = pc + 32'd4;
        issue({6'h3f, 26'($urandom())}, pc);
        wait_valid();
        check_val("unknown regnum", 0, 32'(regnum));
        check_val("unknown write_type", 0, 32'(write_type));
        end_test("bubble");

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
isa_pkg.sv
pipe_pkg.sv
src_if.sv
reg_file.sv
instr_decoder.sv
hazard_check.sv
id_stage.sv
decode_top.sv
tb_clkgen.sv
tb_decode.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_decode
FILELIST  = all.f
SOURCES   = $(shell grep -v '^+' $(FILELIST))
BIN       = obj_dir/V$(TOP)
LOG       = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
